/* Makefile */
TOP := axi_wr_stats_tb

.PHONY: all lint clean

# build, run, then judge the log
all:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
	  --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	  if [ $$status -ne 0 ] || grep -q "Something failed" sim.log; then \
	    echo "simulation failed"; exit 1; \
	  fi

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* bench/axi_wr_stats_props.sv */
`timescale 1ns/100ps

`include "axi_wr_stats_config.svh"

module axi_wr_stats_props
  import axi_wr_stats_pkg::*;
(
  input logic                   clk,
  input logic                   rst_n,
  input logic                   arready,
  input logic                   rvalid,
  input logic                   rready,
  input logic [`STAT_WIDTH-1:0] rdata,
  input logic [1:0]             rresp,
  input bucket_t                buckets
);

  // response holds while the master back-pressures
  property rsp_held;
    @(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp);
  endproperty

  rsp_held_a: assert property (rsp_held)
    else $error("read response changed while rready was low");

  arready_a: assert property (@(posedge clk) disable iff (!rst_n)
    arready == (!rvalid || rready))
    else $error("arready does not follow the free response slot");

  // at most one bucket per cycle
  bucket_a: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(buckets))
    else $error("more than one cycle bucket active");

endmodule

/* bench/axi_wr_stats_tb.sv */
`timescale 1ns/100ps

`include "axi_wr_stats_config.svh"

module axi_wr_stats_tb
  import axi_wr_stats_pkg::*;
();

  localparam int TRAFFIC_CYCLES = 2000;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   stat_clear;
  axi_wr_bus_t            bus;
  axil_addr_u             araddr;
  logic                   arvalid;
  logic                   arready;
  logic                   rvalid;
  logic [`STAT_WIDTH-1:0] rdata;
  logic [1:0]             rresp;
  logic                   rready;

  integer seed = 52386;
  int     errors = 0;

  // reference model state
  int          m_evt[4];
  int          m_aw_out;
  int          m_w_out;
  int          m_aw_max;
  int          m_w_max;
  logic        m_wip;
  bucket_t     m_bkt_reg;
  int          m_bkt_cnt[12];
  logic [39:0] exp_q[$];

  always #10 clk = ~clk;

  axi_wr_stats axi_wr_stats_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .stat_clear(stat_clear),
    .bus       (bus),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .rresp     (rresp),
    .rready    (rready)
  );

  bind axi_wr_stats axi_wr_stats_props props_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .arready(arready),
    .rvalid (rvalid),
    .rready (rready),
    .rdata  (rdata),
    .rresp  (rresp),
    .buckets(buckets)
  );

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic int rand_below(input int n);
    int unsigned r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------

  // one cycle of the bucket priority table where the first true condition wins
  function automatic bucket_t classify(input logic aw_busy, input logic w_busy,
                                       input logic wip, input axi_wr_bus_t b);
    bucket_t r;
    logic    w_quiet;
    logic    b_wait;
    r = '0;
    w_quiet = !b.wvalid;
    b_wait = aw_busy && w_busy && !wip && w_quiet;
    if (!aw_busy && !w_busy && !wip && !b.awvalid && w_quiet) r.idle = 1'b1;
    else if (aw_busy && wip && w_quiet) r.slow_data = 1'b1;
    else if ((aw_busy || wip) && b.wvalid && !b.wready) r.stall = 1'b1;
    else if (!aw_busy && !b.awvalid && b.wvalid && b.wready) r.early_beat = 1'b1;
    else if (!aw_busy && !w_busy && !wip && b.awvalid && w_quiet) begin
      if (b.awready) r.awr_early = 1'b1;
      else r.addr_stall = 1'b1;
    end
    else if (aw_busy && !w_busy && !wip && w_quiet) r.data_lag = 1'b1;
    else if (!aw_busy && (w_busy || wip) && w_quiet) r.addr_lag = 1'b1;
    else if (!aw_busy && !wip && b.wvalid && !b.wready) r.early_stall = 1'b1;
    else if (b_wait && !b.bvalid) r.b_lag = 1'b1;
    else if (b_wait && !b.bready) r.b_stall = 1'b1;
    else if (b_wait) r.b_end = 1'b1;
    return r;
  endfunction

  function automatic logic [31:0] model_value(input int idx);
    if (idx < 4) return m_evt[idx];
    if (idx == 4) return m_aw_max;
    if (idx == 5) return m_w_max;
    return m_bkt_cnt[idx-6];
  endfunction

  always @(posedge clk) begin
    int      idx;
    logic    aw_f;
    logic    w_f;
    logic    b_f;
    bucket_t nxt_bkt;
    aw_f = bus.awvalid && bus.awready;
    w_f = bus.wvalid && bus.wready;
    b_f = bus.bvalid && bus.bready;
    // the bank value on the accept cycle is what comes back
    if (rst_n && arvalid && arready) begin
      idx = int'(araddr.reg_view.idx);
      if (idx < `STAT_COUNT) exp_q.push_back({6'(idx), 2'b00, model_value(idx)});
      else exp_q.push_back({6'(idx), 2'b11, 32'h0});
    end
    nxt_bkt = classify(m_aw_out != 0, m_w_out != 0, m_wip, bus);
    if (!rst_n || stat_clear) begin
      m_evt = '{default: 0};
      m_bkt_cnt = '{default: 0};
      m_bkt_reg = '0;
      m_aw_out = 0;
      m_w_out = 0;
      m_aw_max = 0;
      m_w_max = 0;
    end else begin
      for (int k = 0; k < 12; k++) begin
        if (m_bkt_reg[11-k]) m_bkt_cnt[k]++;
      end
      m_bkt_reg = nxt_bkt;
      if (aw_f) m_evt[0]++;
      if (w_f && bus.wlast) m_evt[1]++;
      if (w_f) m_evt[2]++;
      if (b_f && bus.bresp != 2'b00) m_evt[3]++;
      if (m_aw_out > m_aw_max) m_aw_max = m_aw_out;
      if (m_w_out > m_w_max) m_w_max = m_w_out;
      if (aw_f) m_aw_out++;
      if (w_f && bus.wlast) m_w_out++;
      if (b_f) begin
        m_aw_out--;
        m_w_out--;
      end
    end
    if (!rst_n) m_wip = 1'b0;
    else if (bus.wvalid) m_wip = !(bus.wready && bus.wlast);
  end

  // compare every completed read against the value captured at accept
  always @(posedge clk) begin
    logic [39:0] exp_word;
    if (rst_n && rvalid && rready) begin
      assert (exp_q.size() != 0) else begin
        $display("read response arrived with no read outstanding");
        errors++;
      end
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        assert (rdata === exp_word[31:0]) else begin
          $display("CHECK FAILED rdata reg %0d got %h expected %h",
                   exp_word[39:34], rdata, exp_word[31:0]);
          errors++;
        end
        assert (rresp === exp_word[33:32]) else begin
          $display("CHECK FAILED rresp reg %0d got %h expected %h",
                   exp_word[39:34], rresp, exp_word[33:32]);
          errors++;
        end
      end
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  task automatic read_reg(input logic [5:0] idx, input int hold);
    axil_addr_u  addr;
    logic [31:0] held_data;
    logic [1:0]  held_resp;
    addr.reg_view.idx = idx;
    addr.reg_view.offset = 2'(rand_below(4));
    @(posedge clk);
    araddr <= addr;
    arvalid <= 1'b1;
    if (hold > 0) rready <= 1'b0;
    do @(posedge clk); while (!arready);
    if (hold > 0) begin
      // a second request waits behind the stalled response
      addr.reg_view.idx = 6'(rand_below(`STAT_COUNT));
      araddr <= addr;
      do @(posedge clk); while (!rvalid);
      held_data = rdata;
      held_resp = rresp;
      repeat (hold) begin
        @(posedge clk);
        assert (rdata === held_data && rresp === held_resp) else begin
          $display("CHECK FAILED rdata %h rresp %h moved from %h %h during stall",
                   rdata, rresp, held_data, held_resp);
          errors++;
        end
      end
      rready <= 1'b1;
      do @(posedge clk); while (!arready);
    end
    arvalid <= 1'b0;
    do @(posedge clk); while (!(rvalid && rready));
  endtask

  task automatic read_all();
    for (int i = 0; i < `STAT_COUNT; i++) begin
      read_reg(6'(i), 0);
    end
  endtask

  // random handshakes with b only once an address and a last beat are pending
  task automatic drive_traffic(input int cycles);
    int          pend_aw;
    int          pend_w;
    axi_wr_bus_t nxt;
    pend_aw = 0;
    pend_w = 0;
    repeat (cycles) begin
      @(posedge clk);
      if (bus.awvalid && bus.awready) pend_aw++;
      if (bus.wvalid && bus.wready && bus.wlast) pend_w++;
      if (bus.bvalid && bus.bready) begin
        pend_aw--;
        pend_w--;
      end
      nxt.awvalid = rand_bit() && pend_aw < 8;
      nxt.awready = rand_bit();
      nxt.wvalid = rand_bit();
      nxt.wready = rand_bit();
      nxt.wlast = rand_bit() && pend_w < 8;
      nxt.bvalid = rand_bit() && pend_aw > 0 && pend_w > 0;
      nxt.bready = rand_bit();
      nxt.bresp = 2'(rand_below(4));
      bus <= nxt;
    end
    // close the open burst and leave the bus quiet
    nxt = '0;
    nxt.wvalid = 1'b1;
    nxt.wready = 1'b1;
    nxt.wlast = 1'b1;
    @(posedge clk);
    bus <= nxt;
    @(posedge clk);
    bus <= '0;
  endtask

  initial begin
    rst_n = 1'b0;
    stat_clear = 1'b0;
    bus = '0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b1;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (rvalid === 1'b0) else begin
      $display("CHECK FAILED rvalid got %h expected 0 after reset", rvalid);
      errors++;
    end
    read_all();
    fork
      drive_traffic(TRAFFIC_CYCLES);
      repeat (100) begin
        repeat (rand_below(16)) @(posedge clk);
        read_reg(6'(rand_below(`STAT_COUNT)), 0);
      end
    join
    repeat (5) @(posedge clk);
    read_all();
    read_reg(6'd20, 1 + rand_below(8));
    @(posedge clk);
    stat_clear <= 1'b1;
    @(posedge clk);
    stat_clear <= 1'b0;
    read_all();
    repeat (2) @(posedge clk);
    assert (exp_q.size() == 0) else begin
      $display("%0d accepted reads never returned a response", exp_q.size());
      errors++;
    end
    $display("run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // every phase plus the reads fits well inside this bound
  initial begin
    #((TRAFFIC_CYCLES + 400) * 40);
    $display("timeout, the test did not finish in time");
    $display("Something failed");
    $finish;
  end

endmodule

/* rtl/axi_wr_stats.sv */
`timescale 1ns/100ps

`include "axi_wr_stats_config.svh"

module axi_wr_stats
  import axi_wr_stats_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stat_clear,
  input  axi_wr_bus_t            bus,
  input  axil_addr_u             araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic                   rvalid,
  output logic [`STAT_WIDTH-1:0] rdata,
  output logic [1:0]             rresp,
  input  logic                   rready
);

  localparam int NUM_CNT = 16;

  wr_events_t             events;
  depth_t                 depth;
  bucket_t                buckets;
  logic [11:0]            bucket_bits;
  logic                   stat_inc[NUM_CNT];
  logic [`STAT_WIDTH-1:0] cnt_val[NUM_CNT];
  stat_bank_t             stats;

  // --------------------------------------------------
  // bus event decode
  // --------------------------------------------------

  assign events.aw_fire     = bus.awvalid && bus.awready;
  assign events.w_fire      = bus.wvalid && bus.wready;
  assign events.w_last_fire = bus.wvalid && bus.wready && bus.wlast;
  assign events.b_fire      = bus.bvalid && bus.bready;
  assign events.b_err       = bus.bvalid && bus.bready && (bus.bresp != 2'b00);

  outstanding_tracker outstanding_tracker_i (
    .clk   (clk),
    .rst_n (rst_n),
    .clr   (stat_clear),
    .events(events),
    .depth (depth)
  );

  write_cycle_classifier write_cycle_classifier_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .clr    (stat_clear),
    .bus    (bus),
    .depth  (depth),
    .buckets(buckets)
  );

  // --------------------------------------------------
  // counter bank
  // --------------------------------------------------

  // idle sits in the top bit of the bucket struct
  assign bucket_bits = buckets;

  always_comb begin
    stat_inc[0] = events.aw_fire;
    stat_inc[1] = events.w_last_fire;
    stat_inc[2] = events.w_fire;
    stat_inc[3] = events.b_err;
    for (int i = 0; i < 12; i++) begin
      stat_inc[4+i] = bucket_bits[11-i];
    end
  end

  for (genvar k = 0; k < NUM_CNT; k++) begin : g_cnt
    stat_counter #(
      .WIDTH(`STAT_WIDTH)
    ) stat_counter_i (
      .clk  (clk),
      .rst_n(rst_n),
      .clr  (stat_clear),
      .inc  (stat_inc[k]),
      .dec  (1'b0),
      .cnt  (cnt_val[k])
    );
  end

  // registers 4 and 5 are the depth peaks, the rest come from counters
  always_comb begin
    stats[int'(STAT_AW_BURST_CNT)] = cnt_val[0];
    stats[int'(STAT_W_BURST_CNT)]  = cnt_val[1];
    stats[int'(STAT_W_BEAT_CNT)]   = cnt_val[2];
    stats[int'(STAT_ERR_CNT)]      = cnt_val[3];
    stats[int'(STAT_AW_DEPTH_MAX)] = `STAT_WIDTH'(depth.aw_max);
    stats[int'(STAT_W_DEPTH_MAX)]  = `STAT_WIDTH'(depth.w_max);
    for (int i = 0; i < 12; i++) begin
      stats[int'(STAT_IDLE)+i] = cnt_val[4+i];
    end
  end

  stat_reg_read stat_reg_read_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rvalid (rvalid),
    .rdata  (rdata),
    .rresp  (rresp),
    .rready (rready),
    .stats  (stats)
  );

endmodule

/* rtl/axi_wr_stats_config.svh */
`ifndef AXI_WR_STATS_CONFIG_SVH
`define AXI_WR_STATS_CONFIG_SVH

// --------------------------------------------------
// sizing of the write-side statistics block
// --------------------------------------------------

// width of every statistic and of the axi-lite read data
`define STAT_WIDTH 32

// axi-lite byte address, 6 bit index plus 2 bit byte offset
`define AXIL_ADDR_WIDTH 8

// outstanding burst counters and their maxima
`define DEPTH_WIDTH 8

// registers 0 to 17 are mapped, anything above reads as an error
`define STAT_COUNT 18

`endif

/* rtl/axi_wr_stats_pkg.sv */
`include "axi_wr_stats_config.svh"

package axi_wr_stats_pkg;

  // register map, one 32 bit word per statistic
  typedef enum logic [5:0] {
    STAT_AW_BURST_CNT = 6'd0,
    STAT_W_BURST_CNT  = 6'd1,
    STAT_W_BEAT_CNT   = 6'd2,
    STAT_ERR_CNT      = 6'd3,
    STAT_AW_DEPTH_MAX = 6'd4,
    STAT_W_DEPTH_MAX  = 6'd5,
    STAT_IDLE         = 6'd6,
    STAT_SLOW_DATA    = 6'd7,
    STAT_STALL        = 6'd8,
    STAT_EARLY_BEAT   = 6'd9,
    STAT_AWR_EARLY    = 6'd10,
    STAT_ADDR_STALL   = 6'd11,
    STAT_DATA_LAG     = 6'd12,
    STAT_ADDR_LAG     = 6'd13,
    STAT_EARLY_STALL  = 6'd14,
    STAT_B_LAG        = 6'd15,
    STAT_B_STALL      = 6'd16,
    STAT_B_END        = 6'd17
  } stat_id_t;

  // read address seen either as a byte address or as word index plus offset
  typedef union packed {
    logic [`AXIL_ADDR_WIDTH-1:0] raw;
    struct packed {
      logic [5:0] idx;
      logic [1:0] offset;
    } reg_view;
  } axil_addr_u;

  // handshake and response bits of the monitored write bus
  typedef struct packed {
    logic       awvalid;
    logic       awready;
    logic       wvalid;
    logic       wready;
    logic       wlast;
    logic       bvalid;
    logic       bready;
    logic [1:0] bresp;
  } axi_wr_bus_t;

  typedef struct packed {
    logic aw_fire;
    logic w_fire;
    logic w_last_fire;
    logic b_fire;
    logic b_err;
  } wr_events_t;

  typedef struct packed {
    logic [`DEPTH_WIDTH-1:0] aw_cnt;
    logic [`DEPTH_WIDTH-1:0] w_cnt;
    logic [`DEPTH_WIDTH-1:0] aw_max;
    logic [`DEPTH_WIDTH-1:0] w_max;
  } depth_t;

  // one enable per cycle bucket, same order as registers 6 to 17
  typedef struct packed {
    logic idle;
    logic slow_data;
    logic stall;
    logic early_beat;
    logic awr_early;
    logic addr_stall;
    logic data_lag;
    logic addr_lag;
    logic early_stall;
    logic b_lag;
    logic b_stall;
    logic b_end;
  } bucket_t;

  typedef logic [`STAT_WIDTH-1:0] stat_bank_t[`STAT_COUNT];

endpackage

/* rtl/outstanding_tracker.sv */
`timescale 1ns/100ps

`include "axi_wr_stats_config.svh"

module outstanding_tracker
  import axi_wr_stats_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       clr,
  input  wr_events_t events,
  output depth_t     depth
);

  logic [`DEPTH_WIDTH-1:0] aw_cnt;
  logic [`DEPTH_WIDTH-1:0] w_cnt;
  logic [`DEPTH_WIDTH-1:0] aw_max;
  logic [`DEPTH_WIDTH-1:0] w_max;

  // address accepted up to its write response
  stat_counter #(
    .WIDTH(`DEPTH_WIDTH)
  ) aw_cnt_i (
    .clk  (clk),
    .rst_n(rst_n),
    .clr  (clr),
    .inc  (events.aw_fire),
    .dec  (events.b_fire),
    .cnt  (aw_cnt)
  );

  // last data beat accepted up to its write response
  stat_counter #(
    .WIDTH(`DEPTH_WIDTH)
  ) w_cnt_i (
    .clk  (clk),
    .rst_n(rst_n),
    .clr  (clr),
    .inc  (events.w_last_fire),
    .dec  (events.b_fire),
    .cnt  (w_cnt)
  );

  // peaks lag the counts by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n || clr) begin
      aw_max <= '0;
      w_max  <= '0;
    end else begin
      if (aw_cnt > aw_max) aw_max <= aw_cnt;
      if (w_cnt > w_max) w_max <= w_cnt;
    end
  end

  assign depth = '{aw_cnt: aw_cnt, w_cnt: w_cnt, aw_max: aw_max, w_max: w_max};

endmodule

/* rtl/stat_counter.sv */
`timescale 1ns/100ps

`include "axi_wr_stats_config.svh"

module stat_counter #(
  parameter int WIDTH = `STAT_WIDTH
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clr,
  input  logic             inc,
  input  logic             dec,
  output logic [WIDTH-1:0] cnt
);

  // inc and dec together cancel out, the count wraps at both ends
  always_ff @(posedge clk) begin
    if (!rst_n || clr) begin
      cnt <= '0;
    end else if (inc && !dec) begin
      cnt <= cnt + 1'b1;
    end else if (dec && !inc) begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

/* rtl/stat_reg_read.sv */
`timescale 1ns/100ps

`include "axi_wr_stats_config.svh"

module stat_reg_read
  import axi_wr_stats_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  axil_addr_u             araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic                   rvalid,
  output logic [`STAT_WIDTH-1:0] rdata,
  output logic [1:0]             rresp,
  input  logic                   rready,
  input  stat_bank_t             stats
);

  logic                   ar_fire;
  logic                   mapped;
  logic [`STAT_WIDTH-1:0] sel_data;

  // the response slot is free when empty or draining this cycle
  assign arready = !rvalid || rready;
  assign ar_fire = arvalid && arready;

  // --------------------------------------------------
  // register lookup
  // --------------------------------------------------

  // word index only, the byte offset is ignored
  assign mapped = araddr.reg_view.idx < 6'(`STAT_COUNT);

  always_comb begin
    sel_data = '0;
    for (int i = 0; i < `STAT_COUNT; i++) begin
      if (araddr.reg_view.idx == 6'(i)) sel_data = stats[i];
    end
  end

  // --------------------------------------------------
  // read response
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (ar_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // held while rvalid waits on rready
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata <= sel_data;
      rresp <= mapped ? 2'b00 : 2'b11;
    end
  end

endmodule

/* rtl/write_cycle_classifier.sv */
`timescale 1ns/100ps

module write_cycle_classifier
  import axi_wr_stats_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clr,
  input  axi_wr_bus_t bus,
  input  depth_t      depth,
  output bucket_t     buckets
);

  logic       w_in_progress;
  logic [8:0] cls;
  bucket_t    bucket_next;

  // --------------------------------------------------
  // data burst tracking
  // --------------------------------------------------

  // set by a beat that is not the accepted last one, cleared by the accepted last
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_in_progress <= 1'b0;
    end else if (bus.wvalid) begin
      w_in_progress <= !(bus.wready && bus.wlast);
    end
  end

  // --------------------------------------------------
  // cycle bucketing
  // --------------------------------------------------

  assign cls = {
    depth.aw_cnt != '0,
    depth.w_cnt != '0,
    w_in_progress,
    bus.awvalid,
    bus.awready,
    bus.wvalid,
    bus.wready,
    bus.bvalid,
    bus.bready
  };

  // first match wins, no match leaves every bucket off
  always_comb begin
    bucket_next = '0;
    casez (cls)
      // nothing pending, nothing offered
      9'b0000?0???: bucket_next.idle        = 1'b1;

      // throughput
      9'b1?1??0???: bucket_next.slow_data   = 1'b1;
      9'b1????10??: bucket_next.stall       = 1'b1;
      9'b0?1??10??: bucket_next.stall       = 1'b1;
      9'b0??0?11??: bucket_next.early_beat  = 1'b1;

      // latency
      9'b000110???: bucket_next.awr_early   = 1'b1;
      9'b000100???: bucket_next.addr_stall  = 1'b1;
      9'b100??0???: bucket_next.data_lag    = 1'b1;
      9'b010??0???: bucket_next.addr_lag    = 1'b1;
      9'b0?1??0???: bucket_next.addr_lag    = 1'b1;
      9'b0?0??10??: bucket_next.early_stall = 1'b1;

      // waiting on the write response
      9'b110??0?0?: bucket_next.b_lag       = 1'b1;
      9'b110??0?10: bucket_next.b_stall     = 1'b1;
      9'b110??0?11: bucket_next.b_end       = 1'b1;
      default:      bucket_next             = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clr) begin
      buckets <= '0;
    end else begin
      buckets <= bucket_next;
    end
  end

endmodule

/* sources.f */
+incdir+rtl
rtl/axi_wr_stats_pkg.sv
rtl/stat_counter.sv
rtl/outstanding_tracker.sv
rtl/write_cycle_classifier.sv
rtl/stat_reg_read.sv
rtl/axi_wr_stats.sv
bench/axi_wr_stats_props.sv
bench/axi_wr_stats_tb.sv
